/* sim/core_model.svh */
/*
 * Reference model of the integer core, included into the testbench module.
 * Replays the program in order on its own register array and queues one
 * expected trace record for every instruction that writes a register.
 */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

word_t      model_regs [0:31];
dbg_trace_t expected_q [$];

task automatic run_instruction(input word_t pc, input word_t inst);
    opcode_t    op;
    funct_t     fn;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  dest;
    shamt_t     sa;
    word_t      a;
    word_t      b;
    word_t      simm;
    word_t      zimm;
    word_t      res;
    logic       known;
    dbg_trace_t rec;
    op    = inst[31:26];
    rs    = inst[25:21];
    rt    = inst[20:16];
    sa    = inst[10:6];
    fn    = inst[5:0];
    a     = model_regs[rs];
    b     = model_regs[rt];
    simm  = {{16{inst[15]}}, inst[15:0]};
    zimm  = {16'h0000, inst[15:0]};
    known = 1'b1;
    dest  = rt;
    res   = '0;
    if (op == OP_SPECIAL) begin
        dest = inst[15:11];
        case (fn)
            FN_ADDU: res = a + b;
            FN_SUBU: res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_XOR:  res = a ^ b;
            FN_NOR:  res = ~(a | b);
            FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            FN_SLL:  res = b << sa;
            FN_SRL:  res = b >> sa;
            FN_SRA:  res = $signed(b) >>> sa;
            default: known = 1'b0;
        endcase
    end else begin
        case (op)
            OP_ADDIU: res = a + simm;
            OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & zimm;
            OP_ORI:   res = a | zimm;
            OP_XORI:  res = a ^ zimm;
            OP_LUI:   res = {inst[15:0], 16'h0000};
            default:  known = 1'b0;
        endcase
    end
    // Register 0 stays zero and leaves no trace
    if (known && dest != 5'd0) begin
        model_regs[dest] = res;
        rec = '{pc: pc, wen: 1'b1, wraddr: dest, wrdata: res};
        expected_q.push_back(rec);
    end
endtask

task automatic replay_program();
    for (int r = 0; r < 32; r++) begin
        model_regs[r] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
        run_instruction(RESET_PC + 32'(i) * 32'd4, imem[i]);
    end
endtask

`endif

/* sim/core_tb.sv */
/*
 * Testbench for the integer core. Runs a random program of kept and
 * unsupported instructions under random fetch stalls and compares the
 * writeback trace with the reference model, record by record.
 */
`timescale 1ns/1ps

module core_tb
    import mips_isa_pkg::*, core_pipe_pkg::*;
();

    localparam word_t       RESET_PC    = 32'hBFC0_0000;
    localparam int          PROG_LEN    = 2000;
    localparam int          CYCLE_LIMIT = 4 * PROG_LEN + 100;
    localparam int unsigned SEED        = 32'h807c_14b9;

    logic      clk;
    logic      arst_n_i;
    logic      ibus_streq_i;
    word_t     ibus_rdata_i;
    logic      ibus_en_o;
    word_t     ibus_addr_o;
    word_t     debug_wb_pc_o;
    logic      debug_wb_wen_o;
    reg_addr_t debug_wb_wraddr_o;
    word_t     debug_wb_wrdata_o;

    word_t       imem [0:PROG_LEN-1];
    logic        stall_pattern [0:CYCLE_LIMIT-1];
    reg_addr_t   recent_dst [0:2];
    word_t       fetch_offset;
    word_t       next_fetch_addr = RESET_PC;
    int unsigned fetch_count = 0;
    int unsigned accept_edge [0:PROG_LEN-1];
    int unsigned cycles = 0;
    int unsigned check_count = 0;
    int unsigned error_count = 0;
    int unsigned trace_idx;
    dbg_trace_t  exp_rec;

    `include "core_model.svh"

    mango_core_top #(
        .RESET_PC (RESET_PC)
    ) mango_core_top_i (
        .clk               (clk              ),
        .arst_n_i          (arst_n_i         ),
        .ibus_rdata_i      (ibus_rdata_i     ),
        .ibus_streq_i      (ibus_streq_i     ),
        .ibus_en_o         (ibus_en_o        ),
        .ibus_addr_o       (ibus_addr_o      ),
        .debug_wb_pc_o     (debug_wb_pc_o    ),
        .debug_wb_wen_o    (debug_wb_wen_o   ),
        .debug_wb_wraddr_o (debug_wb_wraddr_o),
        .debug_wb_wrdata_o (debug_wb_wrdata_o)
    );

    always #4 clk = ~clk;

    // Past the end of the program the memory returns sll $0,$0,0
    always_comb begin
        fetch_offset = ibus_addr_o - RESET_PC;
        if (fetch_offset < PROG_LEN * 4) begin
            ibus_rdata_i = imem[fetch_offset[31:2]];
        end else begin
            ibus_rdata_i = '0;
        end
    end

    always @(posedge clk) begin
        cycles       <= cycles + 1;
        ibus_streq_i <= (cycles < CYCLE_LIMIT) ? stall_pattern[cycles] : 1'b0;
    end

    function automatic reg_addr_t pick_source();
        if ($urandom_range(99) < 60) begin
            return recent_dst[$urandom_range(2)];
        end else begin
            return reg_addr_t'($urandom_range(31));
        end
    endfunction

    task automatic make_instruction(output word_t inst, output reg_addr_t dest);
        int unsigned sel;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        shamt_t      sa;
        imm_t        imm;
        opcode_t     op;
        funct_t      fn;
        sel = $urandom_range(18);
        rs  = pick_source();
        rt  = pick_source();
        rd  = reg_addr_t'($urandom_range(31));
        sa  = shamt_t'($urandom_range(31));
        imm = imm_t'($urandom_range(16'hFFFF));
        op  = OP_SPECIAL;
        fn  = FN_ADDU;
        case (sel)
            0:  fn = FN_ADDU;
            1:  fn = FN_SUBU;
            2:  fn = FN_AND;
            3:  fn = FN_OR;
            4:  fn = FN_XOR;
            5:  fn = FN_NOR;
            6:  fn = FN_SLT;
            7:  fn = FN_SLTU;
            8:  fn = FN_SLL;
            9:  fn = FN_SRL;
            10: fn = FN_SRA;
            11: op = OP_ADDIU;
            12: op = OP_SLTI;
            13: op = OP_ANDI;
            14: op = OP_ORI;
            15: op = OP_XORI;
            16: op = OP_LUI;
            // ADD and ADDI trap on overflow and are not part of this core
            17: fn = 6'h20;
            default: op = 6'h08;
        endcase
        if (op == OP_SPECIAL) begin
            inst = {op, rs, rt, rd, sa, fn};
        end else begin
            // Immediate forms carry the destination in the rt field
            inst = {op, rs, rd, imm};
        end
        dest = rd;
    endtask

    task automatic build_program();
        word_t     inst;
        reg_addr_t dest;
        for (int k = 0; k < 3; k++) begin
            recent_dst[k] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            make_instruction(inst, dest);
            imem[i]       = inst;
            recent_dst[2] = recent_dst[1];
            recent_dst[1] = recent_dst[0];
            recent_dst[0] = dest;
        end
        // About one fetch in four is held off by the memory
        for (int c = 0; c < CYCLE_LIMIT; c++) begin
            stall_pattern[c] = ($urandom_range(3) == 0);
        end
    endtask

    always @(negedge clk) begin
        if (!arst_n_i) begin
            check_count++;
            if (ibus_en_o !== 1'b0) begin
                $display("FAILED reset ibus_en: expected 0, actual %b", ibus_en_o);
                error_count++;
            end
            if (debug_wb_wen_o !== 1'b0) begin
                $display("FAILED reset debug_wb_wen: expected 0, actual %b",
                         debug_wb_wen_o);
                error_count++;
            end
        end else begin
            // Enable high and no stall request means the next edge takes the fetch
            if (ibus_en_o && !ibus_streq_i) begin
                check_count++;
                if (ibus_addr_o !== next_fetch_addr) begin
                    $display("FAILED fetch address: expected %h, actual %h",
                             next_fetch_addr, ibus_addr_o);
                    error_count++;
                end
                if (fetch_count < PROG_LEN) begin
                    accept_edge[fetch_count] = cycles + 1;
                end
                fetch_count++;
                next_fetch_addr = next_fetch_addr + 32'd4;
            end
            if (debug_wb_wen_o) begin
                check_count++;
                if (debug_wb_wraddr_o == 5'd0) begin
                    $display("Trace reports a write to register 0 at pc %h", debug_wb_pc_o);
                    error_count++;
                end
                if (expected_q.size() == 0) begin
                    $display("Trace record at pc %h has no matching model record",
                             debug_wb_pc_o);
                    error_count++;
                end else begin
                    exp_rec = expected_q.pop_front();
                    if (debug_wb_pc_o !== exp_rec.pc) begin
                        $display("FAILED trace pc: expected %h, actual %h",
                                 exp_rec.pc, debug_wb_pc_o);
                        error_count++;
                    end
                    if (debug_wb_wraddr_o !== exp_rec.wraddr) begin
                        $display("FAILED trace wraddr: expected %0d, actual %0d",
                                 exp_rec.wraddr, debug_wb_wraddr_o);
                        error_count++;
                    end
                    if (debug_wb_wrdata_o !== exp_rec.wrdata) begin
                        $display("FAILED trace wrdata: expected %h, actual %h",
                                 exp_rec.wrdata, debug_wb_wrdata_o);
                        error_count++;
                    end
                    trace_idx = (exp_rec.pc - RESET_PC) >> 2;
                    if (cycles != accept_edge[trace_idx] + 3) begin
                        $display("FAILED trace latency: expected %0d, actual %0d",
                                 accept_edge[trace_idx] + 3, cycles);
                        error_count++;
                    end
                end
            end
        end
    end

    initial begin
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        ibus_streq_i = 1'b0;
        void'($urandom(SEED));
        build_program();
        replay_program();
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;
        while (fetch_count < PROG_LEN || expected_q.size() != 0) begin
            @(negedge clk);
        end
        // A few more cycles catch stray traces after the last record
        repeat (8) @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        $display("Run timed out after %0d cycles with %0d trace records still expected",
                 cycles, expected_q.size());
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* source/alu_execute.sv */
/*
 * Execute stage. Computes the integer result of one instruction and
 * packs it with its destination for the writeback register.
 */
`timescale 1ns/1ps

module alu_execute
    import mips_isa_pkg::*, core_pipe_pkg::*;
(
    input  id_ex_t id_ex_i,
    output ex_wb_t ex_wb_o
);

    word_t a;
    word_t b;
    word_t result;

    assign a = id_ex_i.opr1;
    assign b = id_ex_i.opr2;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            // Shifts act on rt, which decode placed in operand 2
            ALU_SLL:  result = b << id_ex_i.shamt;
            ALU_SRL:  result = b >> id_ex_i.shamt;
            ALU_SRA:  result = $signed(b) >>> id_ex_i.shamt;
            ALU_LUI:  result = b;
            default:  result = '0;
        endcase
    end

    assign ex_wb_o = '{
        pc:     id_ex_i.pc,
        wen:    id_ex_i.wen,
        wraddr: id_ex_i.wraddr,
        wrdata: result
    };

endmodule

/* source/core_pipe_pkg.sv */
/*
 * Payloads carried between the pipeline stages of the core,
 * and the bundle behind the debug writeback trace ports.
 */
package core_pipe_pkg;

    import mips_isa_pkg::*;

    // Fetch to decode
    typedef struct packed {
        word_t pc;
        word_t inst;
    } if_id_t;

    // Decode to execute, operands already read and extended
    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     opr1;
        word_t     opr2;
        shamt_t    shamt;
        logic      wen;
        reg_addr_t wraddr;
    } id_ex_t;

    // Execute to writeback
    typedef struct packed {
        word_t     pc;
        logic      wen;
        reg_addr_t wraddr;
        word_t     wrdata;
    } ex_wb_t;

    // What the core reports for each retired instruction
    typedef struct packed {
        word_t     pc;
        logic      wen;
        reg_addr_t wraddr;
        word_t     wrdata;
    } dbg_trace_t;

endpackage

/* source/decode_unit.sv */
/*
 * Instruction decode. Reads rs and rt from the register file, selects
 * the ALU operation and builds both operands and the destination.
 */
`timescale 1ns/1ps

module decode_unit
    import mips_isa_pkg::*, core_pipe_pkg::*;
(
    input  logic      valid_i,
    input  if_id_t    if_id_i,
    output reg_addr_t r1addr_o,
    output reg_addr_t r2addr_o,
    input  word_t     r1data_i,
    input  word_t     r2data_i,
    output id_ex_t    id_ex_o
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    shamt_t    sa;
    imm_t      imm;
    alu_op_t   op;
    word_t     opr2;
    reg_addr_t dest;

    assign opcode = if_id_i.inst[31:26];
    assign rs     = if_id_i.inst[25:21];
    assign rt     = if_id_i.inst[20:16];
    assign rd     = if_id_i.inst[15:11];
    assign sa     = if_id_i.inst[10:6];
    assign funct  = if_id_i.inst[5:0];
    assign imm    = if_id_i.inst[15:0];

    assign r1addr_o = rs;
    assign r2addr_o = rt;

    always_comb begin
        op   = ALU_NOP;
        opr2 = r2data_i;
        dest = rd;
        if (opcode == OP_SPECIAL) begin
            case (funct)
                FN_ADDU: op = ALU_ADD;
                FN_SUBU: op = ALU_SUB;
                FN_AND:  op = ALU_AND;
                FN_OR:   op = ALU_OR;
                FN_XOR:  op = ALU_XOR;
                FN_NOR:  op = ALU_NOR;
                FN_SLT:  op = ALU_SLT;
                FN_SLTU: op = ALU_SLTU;
                FN_SLL:  op = ALU_SLL;
                FN_SRL:  op = ALU_SRL;
                FN_SRA:  op = ALU_SRA;
                default: op = ALU_NOP;
            endcase
        end else begin
            // Immediate forms write rt and take the immediate as operand 2
            dest = rt;
            case (opcode)
                OP_ADDIU: op = ALU_ADD;
                OP_SLTI:  op = ALU_SLT;
                OP_ANDI:  op = ALU_AND;
                OP_ORI:   op = ALU_OR;
                OP_XORI:  op = ALU_XOR;
                OP_LUI:   op = ALU_LUI;
                default:  op = ALU_NOP;
            endcase
            if (opcode == OP_ADDIU || opcode == OP_SLTI) begin
                opr2 = {{16{imm[15]}}, imm};
            end else if (opcode == OP_LUI) begin
                opr2 = {imm, 16'h0000};
            end else begin
                opr2 = {16'h0000, imm};
            end
        end
    end

    always_comb begin
        id_ex_o.pc     = if_id_i.pc;
        id_ex_o.alu_op = op;
        id_ex_o.opr1   = r1data_i;
        id_ex_o.opr2   = opr2;
        id_ex_o.shamt  = sa;
        // Bubbles, unknown encodings and writes to $zero leave no trace
        id_ex_o.wen    = valid_i && (op != ALU_NOP) && (dest != '0);
        id_ex_o.wraddr = dest;
    end

endmodule

/* source/fetch_unit.sv */
/*
 * Instruction fetch. Holds the program counter, drives the instruction
 * bus and registers each accepted instruction for the decode stage.
 */
`timescale 1ns/1ps

module fetch_unit
    import mips_isa_pkg::*, core_pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic   clk,
    input  logic   arst_n_i,
    input  logic   ibus_streq_i,
    input  word_t  ibus_rdata_i,
    output logic   ibus_en_o,
    output word_t  ibus_addr_o,
    output logic   fetch_valid_o,
    output if_id_t fetch_o
);

    word_t pc_q;
    logic  accept;

    // The memory holds off a fetch by raising the stall request
    assign accept      = ibus_en_o & ~ibus_streq_i;
    assign ibus_addr_o = pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ibus_en_o     <= 1'b0;
            pc_q          <= RESET_PC;
            fetch_valid_o <= 1'b0;
        end else begin
            ibus_en_o     <= 1'b1;
            fetch_valid_o <= accept;
            if (accept) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fetch_o <= '{pc: pc_q, inst: ibus_rdata_i};
        end
    end

endmodule

/* source/mango_core_top.sv */
/*
 * Top level of the four-stage integer core: fetch, decode, execute and
 * writeback. Connects the instruction bus and exports the writeback trace.
 */
`timescale 1ns/1ps

module mango_core_top
    import mips_isa_pkg::*, core_pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  word_t     ibus_rdata_i,
    input  logic      ibus_streq_i,
    output logic      ibus_en_o,
    output word_t     ibus_addr_o,
    output word_t     debug_wb_pc_o,
    output logic      debug_wb_wen_o,
    output reg_addr_t debug_wb_wraddr_o,
    output word_t     debug_wb_wrdata_o
);

    logic       fetch_valid;
    if_id_t     fetch_data;
    logic       if_id_valid;
    if_id_t     if_id_q;
    reg_addr_t  r1addr;
    reg_addr_t  r2addr;
    word_t      r1data;
    word_t      r2data;
    id_ex_t     id_ex_d;
    logic       id_ex_valid;
    id_ex_t     id_ex_q;
    ex_wb_t     ex_res;
    ex_wb_t     ex_fwd;
    logic       ex_wb_valid;
    ex_wb_t     ex_wb_q;
    ex_wb_t     wb_res;
    dbg_trace_t trace;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_i (
        .clk           (clk         ),
        .arst_n_i      (arst_n_i    ),
        .ibus_streq_i  (ibus_streq_i),
        .ibus_rdata_i  (ibus_rdata_i),
        .ibus_en_o     (ibus_en_o   ),
        .ibus_addr_o   (ibus_addr_o ),
        .fetch_valid_o (fetch_valid ),
        .fetch_o       (fetch_data  )
    );

    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk      (clk        ),
        .arst_n_i (arst_n_i   ),
        .stall_i  (1'b0       ),
        .flush_i  (1'b0       ),
        .valid_i  (fetch_valid),
        .data_i   (fetch_data ),
        .valid_o  (if_id_valid),
        .data_o   (if_id_q    )
    );

    decode_unit decode_unit_i (
        .valid_i  (if_id_valid),
        .if_id_i  (if_id_q    ),
        .r1addr_o (r1addr     ),
        .r2addr_o (r2addr     ),
        .r1data_i (r1data     ),
        .r2data_i (r2data     ),
        .id_ex_o  (id_ex_d    )
    );

    reg_file reg_file_i (
        .clk      (clk     ),
        .arst_n_i (arst_n_i),
        .r1addr_i (r1addr  ),
        .r2addr_i (r2addr  ),
        .r1data_o (r1data  ),
        .r2data_o (r2data  ),
        .ex_fwd_i (ex_fwd  ),
        .wb_i     (wb_res  )
    );

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk      (clk        ),
        .arst_n_i (arst_n_i   ),
        .stall_i  (1'b0       ),
        .flush_i  (1'b0       ),
        .valid_i  (if_id_valid),
        .data_i   (id_ex_d    ),
        .valid_o  (id_ex_valid),
        .data_o   (id_ex_q    )
    );

    alu_execute alu_execute_i (
        .id_ex_i (id_ex_q),
        .ex_wb_o (ex_res )
    );

    stage_reg #(.payload_t(ex_wb_t)) ex_wb_reg (
        .clk      (clk        ),
        .arst_n_i (arst_n_i   ),
        .stall_i  (1'b0       ),
        .flush_i  (1'b0       ),
        .valid_i  (id_ex_valid),
        .data_i   (ex_res     ),
        .valid_o  (ex_wb_valid),
        .data_o   (ex_wb_q    )
    );

    // Payload registers come out of reset unknown, so every write enable
    // that leaves a stage is qualified by that stage's valid bit
    assign ex_fwd = '{
        pc:     ex_res.pc,
        wen:    ex_res.wen & id_ex_valid,
        wraddr: ex_res.wraddr,
        wrdata: ex_res.wrdata
    };

    assign trace = '{
        pc:     ex_wb_q.pc,
        wen:    ex_wb_q.wen & ex_wb_valid,
        wraddr: ex_wb_q.wraddr,
        wrdata: ex_wb_q.wrdata
    };

    // Writeback port and trace see the same retired instruction
    assign wb_res = '{
        pc:     trace.pc,
        wen:    trace.wen,
        wraddr: trace.wraddr,
        wrdata: trace.wrdata
    };

    assign debug_wb_pc_o     = trace.pc;
    assign debug_wb_wen_o    = trace.wen;
    assign debug_wb_wraddr_o = trace.wraddr;
    assign debug_wb_wrdata_o = trace.wrdata;

endmodule

/* source/mips_isa_pkg.sv */
/*
 * MIPS32 instruction-set definitions for the integer core.
 * Field types, primary opcodes, funct codes and the ALU operation set.
 * Imported by the RTL and by the testbench.
 */
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // Primary opcodes of the kept instructions
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0A;
    localparam opcode_t OP_ANDI    = 6'h0C;
    localparam opcode_t OP_ORI     = 6'h0D;
    localparam opcode_t OP_XORI    = 6'h0E;
    localparam opcode_t OP_LUI     = 6'h0F;

    // Funct codes under OP_SPECIAL
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2A;
    localparam funct_t FN_SLTU = 6'h2B;

    // ALU_NOP marks an encoding the core does not execute
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

endpackage

/* source/reg_file.sv */
/*
 * General register file, 31 writable registers plus a hardwired zero.
 * Two combinational read ports bypass results still in the pipeline,
 * the youngest (execute) first, then writeback.
 */
`timescale 1ns/1ps

module reg_file
    import mips_isa_pkg::*, core_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  reg_addr_t r1addr_i,
    input  reg_addr_t r2addr_i,
    output word_t     r1data_o,
    output word_t     r2data_o,
    input  ex_wb_t    ex_fwd_i,
    input  ex_wb_t    wb_i
);

    word_t regs [1:31];

    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (ex_fwd_i.wen && ex_fwd_i.wraddr == addr) begin
            data = ex_fwd_i.wrdata;
        end else if (wb_i.wen && wb_i.wraddr == addr) begin
            data = wb_i.wrdata;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        r1data_o = read_port(r1addr_i);
        r2data_o = read_port(r2addr_i);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wen && wb_i.wraddr != '0) begin
            regs[wb_i.wraddr] <= wb_i.wrdata;
        end
    end

endmodule

/* source/stage_reg.sv */
/*
 * Pipeline register for one payload type with a valid bit.
 * Stall holds the contents, flush turns the slot into a bubble.
 */
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            data_o <= data_i;
        end
    end

endmodule

/* sources.f */
+incdir+sim
source/mips_isa_pkg.sv
source/core_pipe_pkg.sv
source/fetch_unit.sv
source/stage_reg.sv
source/decode_unit.sv
source/reg_file.sv
source/alu_execute.sv
source/mango_core_top.sv
sim/core_tb.sv
